/* include/node_defs.svh */
`ifndef NODE_DEFS_SVH
`define NODE_DEFS_SVH

// data path
`define WORD_WIDTH      16
`define ADDR_WIDTH      11  // byte address, bit 0 unused

// neighbor tables
`define NUM_NEIGHBORS   8
`define HOP_WIDTH       3   // log2 of NUM_NEIGHBORS

// byte bases, one word per entry, stride of two
`define NEIGHBOR_BASE   11'h048
`define BATTERY_BASE    11'h148
`define QVALUE_BASE     11'h1C8

`endif

/* hdl/node_mem_pkg.sv */
`include "node_defs.svh"

package node_mem_pkg;

    // one memory word, used for table entries and packet values
    typedef logic [`WORD_WIDTH-1:0] word_t;

    // byte address into the node memory
    typedef logic [`ADDR_WIDTH-1:0] byte_addr_t;

    // index of a neighbor entry in a table
    typedef logic [`HOP_WIDTH-1:0] hop_t;

    // entry i of a table sits at base + 2*i
    function automatic byte_addr_t table_addr(
        input byte_addr_t base,
        input hop_t       idx
    );
        byte_addr_t offset;
        offset = byte_addr_t'({idx, 1'b0});
        return base + offset;
    endfunction

endpackage

/* hdl/reward_pkg.sv */
package reward_pkg;

    // tag of each packet field, in transmit order
    typedef enum logic [2:0] {
        f_source_id  = 3'd0,
        f_battery    = 3'd1,
        f_qvalue     = 3'd2,
        f_cluster_id = 3'd3,
        f_dest_id    = 3'd4
    } field_e;

    // one tagged packet word
    typedef struct packed {
        field_e              tag;
        node_mem_pkg::word_t value;
    } pkt_word_t;

    // best hop finder
    typedef enum logic {
        find_idle = 1'b0,
        find_scan = 1'b1
    } finder_state_e;

    // reward packet builder, one state per field on the output
    typedef enum logic [3:0] {
        bld_idle    = 4'd0,
        bld_armed   = 4'd1,
        bld_source  = 4'd2,
        bld_battery = 4'd3,
        bld_qvalue  = 4'd4,
        bld_cluster = 4'd5,
        bld_dest    = 4'd6,
        bld_done    = 4'd7
    } builder_state_e;

endpackage

/* hdl/node_mem.sv */
`timescale 1ns/1ps
`include "node_defs.svh"

module node_mem (
    input  logic                      clock,
    input  logic                      we,
    input  node_mem_pkg::byte_addr_t  waddr,
    input  node_mem_pkg::word_t       wdata,
    input  node_mem_pkg::byte_addr_t  raddr_a,
    output node_mem_pkg::word_t       rdata_a,
    input  node_mem_pkg::byte_addr_t  raddr_b,
    output node_mem_pkg::word_t       rdata_b
);

    localparam int MEM_WORDS = 1 << (`ADDR_WIDTH - 1);

    node_mem_pkg::word_t mem [0:MEM_WORDS-1];

    // word index, byte bit 0 dropped
    logic [`ADDR_WIDTH-2:0] widx;
    logic [`ADDR_WIDTH-2:0] ridx_a;
    logic [`ADDR_WIDTH-2:0] ridx_b;

    assign widx   = waddr[`ADDR_WIDTH-1:1];
    assign ridx_a = raddr_a[`ADDR_WIDTH-1:1];
    assign ridx_b = raddr_b[`ADDR_WIDTH-1:1];

    always_ff @(posedge clock) begin
        if (we) begin
            mem[widx] <= wdata;
        end
    end

    // port a for the finder, port b for the builder
    assign rdata_a = mem[ridx_a];
    assign rdata_b = mem[ridx_b];

    // host loads whole words only
    a_even_waddr: assert property (
        @(posedge clock) we |-> (waddr[0] == 1'b0)
    ) else $error("node_mem: odd write address %h", waddr);

endmodule

/* hdl/best_hop_finder.sv */
`timescale 1ns/1ps
`include "node_defs.svh"

module best_hop_finder (
    input  logic                      clock,
    input  logic                      nrst,
    input  logic                      start,
    output node_mem_pkg::byte_addr_t  rd_addr,
    input  node_mem_pkg::word_t       rd_data,
    output node_mem_pkg::hop_t        best_hop,
    output logic                      hop_valid
);

    localparam node_mem_pkg::hop_t LAST_IDX = node_mem_pkg::hop_t'(`NUM_NEIGHBORS - 1);

    reward_pkg::finder_state_e state;
    node_mem_pkg::hop_t        idx;      // entry being read
    node_mem_pkg::word_t       best_val; // running maximum
    logic                      take;

    assign rd_addr = node_mem_pkg::table_addr(`QVALUE_BASE, idx);

    // strict compare keeps the lower index on a tie
    assign take = (idx == '0) || (rd_data > best_val);

    always_ff @(posedge clock) begin
        if (!nrst) begin
            state     <= reward_pkg::find_idle;
            idx       <= '0;
            hop_valid <= 1'b0;
        end else begin
            hop_valid <= 1'b0;
            case (state)
                reward_pkg::find_idle: begin
                    if (start) begin
                        state <= reward_pkg::find_scan;
                        idx   <= '0;
                    end
                end
                reward_pkg::find_scan: begin
                    idx <= idx + 1'b1;
                    if (idx == LAST_IDX) begin
                        state     <= reward_pkg::find_idle;
                        hop_valid <= 1'b1;
                    end
                end
                default: begin
                    state <= reward_pkg::find_idle;
                end
            endcase
        end
    end

    // running max and its index
    always_ff @(posedge clock) begin
        if (state == reward_pkg::find_scan && take) begin
            best_val <= rd_data;
            best_hop <= idx;
        end
    end

    a_hop_valid_pulse: assert property (
        @(posedge clock) disable iff (!nrst)
        hop_valid |=> !hop_valid
    ) else $error("best_hop_finder: hop_valid wider than one cycle");

    // pulse only follows a walk over every entry
    a_hop_valid_after_scan: assert property (
        @(posedge clock) disable iff (!nrst)
        hop_valid |-> ($past(state == reward_pkg::find_scan)
                       && $past(state == reward_pkg::find_scan, `NUM_NEIGHBORS))
    ) else $error("best_hop_finder: hop_valid without a full scan");

endmodule

/* hdl/reward_packet.sv */
`timescale 1ns/1ps
`include "node_defs.svh"

module reward_packet (
    input  logic                      clock,
    input  logic                      nrst,
    input  logic                      en,
    input  node_mem_pkg::word_t       my_node_id,
    input  node_mem_pkg::word_t       my_cluster_id,
    input  node_mem_pkg::hop_t        action,
    input  node_mem_pkg::hop_t        best_hop,
    input  logic                      hop_valid,
    output node_mem_pkg::byte_addr_t  address,
    input  node_mem_pkg::word_t       data_in,
    output reward_pkg::pkt_word_t     pkt,
    output logic                      pkt_valid,
    output logic                      done
);

    reward_pkg::builder_state_e state;
    node_mem_pkg::hop_t         hop_q; // best hop latched at hop_valid

    // address runs one state ahead of the field on pkt
    always_comb begin
        case (state)
            reward_pkg::bld_source:  address = node_mem_pkg::table_addr(`BATTERY_BASE, hop_q);
            reward_pkg::bld_battery: address = node_mem_pkg::table_addr(`QVALUE_BASE, hop_q);
            reward_pkg::bld_qvalue,
            reward_pkg::bld_cluster: address = node_mem_pkg::table_addr(`NEIGHBOR_BASE, action);
            default:                 address = '0;
        endcase
    end

    always_ff @(posedge clock) begin
        if (state == reward_pkg::bld_armed && hop_valid) begin
            hop_q <= best_hop;
        end
    end

    always_ff @(posedge clock) begin
        if (!nrst) begin
            state     <= reward_pkg::bld_idle;
            pkt       <= '0;
            pkt_valid <= 1'b0;
            done      <= 1'b0;
        end else begin
            case (state)
                reward_pkg::bld_idle: begin
                    done <= 1'b0;
                    if (en) begin
                        state <= reward_pkg::bld_armed;
                    end
                end
                reward_pkg::bld_armed: begin
                    if (hop_valid) begin
                        state     <= reward_pkg::bld_source;
                        pkt       <= '{tag: reward_pkg::f_source_id, value: my_node_id};
                        pkt_valid <= 1'b1;
                    end
                end
                reward_pkg::bld_source: begin
                    state <= reward_pkg::bld_battery;
                    pkt   <= '{tag: reward_pkg::f_battery, value: data_in};
                end
                reward_pkg::bld_battery: begin
                    state <= reward_pkg::bld_qvalue;
                    pkt   <= '{tag: reward_pkg::f_qvalue, value: data_in};
                end
                reward_pkg::bld_qvalue: begin
                    state <= reward_pkg::bld_cluster;
                    pkt   <= '{tag: reward_pkg::f_cluster_id, value: my_cluster_id};
                end
                reward_pkg::bld_cluster: begin
                    state <= reward_pkg::bld_dest;
                    pkt   <= '{tag: reward_pkg::f_dest_id, value: data_in};
                end
                reward_pkg::bld_dest: begin
                    state     <= reward_pkg::bld_done;
                    pkt_valid <= 1'b0;
                    done      <= 1'b1;
                end
                reward_pkg::bld_done: begin
                    state <= reward_pkg::bld_idle;
                    done  <= 1'b0;
                end
                default: begin
                    state     <= reward_pkg::bld_idle;
                    pkt_valid <= 1'b0;
                    done      <= 1'b0;
                end
            endcase
        end
    end

    // five fields back to back, then done with the stream closed
    a_packet_shape: assert property (
        @(posedge clock) disable iff (!nrst)
        (state == reward_pkg::bld_armed && hop_valid)
            |=> pkt_valid [*5] ##1 (done && !pkt_valid)
    ) else $error("reward_packet: packet not five fields followed by done");

endmodule

/* hdl/node_top.sv */
`timescale 1ns/1ps

module node_top (
    input  logic                      clock,
    input  logic                      nrst,
    input  logic                      en,
    input  logic                      start,
    input  node_mem_pkg::word_t       my_node_id,
    input  node_mem_pkg::word_t       my_cluster_id,
    input  node_mem_pkg::hop_t        action,
    input  logic                      load_we,
    input  node_mem_pkg::byte_addr_t  load_addr,
    input  node_mem_pkg::word_t       load_data,
    output reward_pkg::pkt_word_t     pkt,
    output logic                      pkt_valid,
    output logic                      done,
    output node_mem_pkg::hop_t        best_hop
);

    node_mem_pkg::byte_addr_t finder_addr;
    node_mem_pkg::word_t      finder_data;
    node_mem_pkg::byte_addr_t builder_addr;
    node_mem_pkg::word_t      builder_data;
    logic                     hop_valid;

    node_mem u_mem (
        .clock   (clock),
        .we      (load_we),
        .waddr   (load_addr),
        .wdata   (load_data),
        .raddr_a (finder_addr),
        .rdata_a (finder_data),
        .raddr_b (builder_addr),
        .rdata_b (builder_data)
    );

    best_hop_finder u_finder (
        .clock     (clock),
        .nrst      (nrst),
        .start     (start),
        .rd_addr   (finder_addr),
        .rd_data   (finder_data),
        .best_hop  (best_hop),
        .hop_valid (hop_valid)
    );

    reward_packet u_builder (
        .clock         (clock),
        .nrst          (nrst),
        .en            (en),
        .my_node_id    (my_node_id),
        .my_cluster_id (my_cluster_id),
        .action        (action),
        .best_hop      (best_hop),
        .hop_valid     (hop_valid), // finder pulse starts the packet
        .address       (builder_addr),
        .data_in       (builder_data),
        .pkt           (pkt),
        .pkt_valid     (pkt_valid),
        .done          (done)
    );

endmodule

/* tests/tb_node_top.sv */
`timescale 1ns/1ps
`include "node_defs.svh"

module tb_node_top;

    localparam int SEED         = 57109;
    localparam int NUM_PACKETS  = 8;   // armed packets plus the en-low window
    localparam int NUM_LOADS    = 7;
    localparam int LOAD_CYCLES  = 3 * `NUM_NEIGHBORS + 1;
    localparam int RESET_CYCLES = 4;
    localparam int TIMEOUT_CYCLES = 40 * NUM_PACKETS + NUM_LOADS * LOAD_CYCLES + RESET_CYCLES;

    logic                      clock;
    logic                      nrst;
    logic                      en;
    logic                      start;
    node_mem_pkg::word_t       my_node_id;
    node_mem_pkg::word_t       my_cluster_id;
    node_mem_pkg::hop_t        action;
    logic                      load_we;
    node_mem_pkg::byte_addr_t  load_addr;
    node_mem_pkg::word_t       load_data;
    reward_pkg::pkt_word_t     pkt;
    logic                      pkt_valid;
    logic                      done;
    node_mem_pkg::hop_t        best_hop;

    // shadow of the loaded tables
    node_mem_pkg::word_t nbr_tab [`NUM_NEIGHBORS];
    node_mem_pkg::word_t bat_tab [`NUM_NEIGHBORS];
    node_mem_pkg::word_t qv_tab  [`NUM_NEIGHBORS];

    reward_pkg::pkt_word_t exp_q [$];
    int cyc        = 0;
    int start_cyc  = 0;
    int field_idx  = 0;
    int done_count = 0;
    int err_count  = 0;
    int pass_count = 0;
    int fail_count = 0;

    node_top uut (
        .clock         (clock),
        .nrst          (nrst),
        .en            (en),
        .start         (start),
        .my_node_id    (my_node_id),
        .my_cluster_id (my_cluster_id),
        .action        (action),
        .load_we       (load_we),
        .load_addr     (load_addr),
        .load_data     (load_data),
        .pkt           (pkt),
        .pkt_valid     (pkt_valid),
        .done          (done),
        .best_hop      (best_hop)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    always @(posedge clock) begin
        cyc <= cyc + 1;
        if (cyc >= TIMEOUT_CYCLES) begin
            $display("timeout: run went past %0d cycles without finishing", TIMEOUT_CYCLES);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("Fail %s: expected %h, got %h", name, exp, act);
            err_count++;
        end
    endtask

    // largest unsigned q-value with ties going to the lower index
    function automatic node_mem_pkg::hop_t ref_best_hop();
        node_mem_pkg::hop_t best;
        int i;
        best = '0;
        for (i = 1; i < `NUM_NEIGHBORS; i++) begin
            if (qv_tab[i] > qv_tab[best]) begin
                best = node_mem_pkg::hop_t'(i);
            end
        end
        return best;
    endfunction

    function automatic reward_pkg::pkt_word_t ref_field(input int f, input node_mem_pkg::hop_t act);
        reward_pkg::pkt_word_t w;
        node_mem_pkg::hop_t    best;
        best = ref_best_hop();
        case (f)
            0:       w = '{tag: reward_pkg::f_source_id, value: my_node_id};
            1:       w = '{tag: reward_pkg::f_battery, value: bat_tab[best]};
            2:       w = '{tag: reward_pkg::f_qvalue, value: qv_tab[best]};
            3:       w = '{tag: reward_pkg::f_cluster_id, value: my_cluster_id};
            default: w = '{tag: reward_pkg::f_dest_id, value: nbr_tab[act]};
        endcase
        return w;
    endfunction

    // compare every streamed field against the expected queue
    always @(posedge clock) begin : compare_proc
        reward_pkg::pkt_word_t exp_word;
        if (pkt_valid) begin
            if (exp_q.size() == 0) begin
                $display("pkt_valid seen at cycle %0d while no packet was expected", cyc);
                err_count++;
            end else begin
                exp_word = exp_q.pop_front();
                if (field_idx == 0) begin
                    check_value("pkt_valid latency", `NUM_NEIGHBORS + 2, cyc - start_cyc);
                end
                check_value("pkt.tag", 32'(exp_word.tag), 32'(pkt.tag));
                check_value("pkt.value", 32'(exp_word.value), 32'(pkt.value));
                field_idx++;
            end
        end
        if (done) begin
            if (field_idx != 5) begin
                $display("done arrived after %0d fields instead of five", field_idx);
                err_count++;
            end else begin
                check_value("done latency", `NUM_NEIGHBORS + 7, cyc - start_cyc);
            end
            field_idx = 0;
            done_count++;
        end
    end

    task automatic random_tables();
        int i;
        for (i = 0; i < `NUM_NEIGHBORS; i++) begin
            nbr_tab[i] = node_mem_pkg::word_t'($urandom);
            bat_tab[i] = node_mem_pkg::word_t'($urandom);
            qv_tab[i]  = node_mem_pkg::word_t'($urandom);
        end
    endtask

    task automatic write_word(input node_mem_pkg::byte_addr_t a, input node_mem_pkg::word_t d);
        @(negedge clock);
        load_we   = 1'b1;
        load_addr = a;
        load_data = d;
    endtask

    task automatic load_tables();
        int i;
        for (i = 0; i < `NUM_NEIGHBORS; i++) begin
            write_word(node_mem_pkg::byte_addr_t'(`NEIGHBOR_BASE + 2 * i), nbr_tab[i]);
            write_word(node_mem_pkg::byte_addr_t'(`BATTERY_BASE + 2 * i), bat_tab[i]);
            write_word(node_mem_pkg::byte_addr_t'(`QVALUE_BASE + 2 * i), qv_tab[i]);
        end
        @(negedge clock);
        load_we = 1'b0;
    endtask

    task automatic pulse_start();
        @(negedge clock);
        start     = 1'b1;
        start_cyc = cyc;  // edge that samples start
        @(negedge clock);
        start = 1'b0;
    endtask

    task automatic run_packet(input node_mem_pkg::hop_t act);
        int prev;
        int f;
        @(negedge clock);
        en     = 1'b1;
        action = act;
        for (f = 0; f < 5; f++) begin
            exp_q.push_back(ref_field(f, act));
        end
        prev = done_count;
        pulse_start();
        while (done_count == prev) begin
            @(negedge clock);
        end
        check_value("best_hop", 32'(ref_best_hop()), 32'(best_hop));
        check_value("pending fields", 0, exp_q.size());
        en = 1'b0;  // builder stays idle until the next packet
    endtask

    task automatic report_test(input int num, input string name, input int err_before);
        if (err_count == err_before) begin
            pass_count++;
            $display("test %0d %s: passed", num, name);
        end else begin
            fail_count++;
            $display("test %0d %s: failed with %0d errors", num, name, err_count - err_before);
        end
    endtask

    initial begin
        int err0;
        int k;
        int prev;
        node_mem_pkg::hop_t next_best;
        void'($urandom(SEED));
        nrst          = 1'b0;
        en            = 1'b0;
        start         = 1'b0;
        my_node_id    = '0;
        my_cluster_id = '0;
        action        = '0;
        load_we       = 1'b0;
        load_addr     = '0;
        load_data     = '0;
        repeat (RESET_CYCLES) @(posedge clock);
        @(negedge clock);
        nrst          = 1'b1;
        my_node_id    = node_mem_pkg::word_t'($urandom);
        my_cluster_id = node_mem_pkg::word_t'($urandom);

        err0 = err_count;
        for (k = 0; k < 3; k++) begin
            check_value("pkt_valid", 0, 32'(pkt_valid));
            check_value("done", 0, 32'(done));
            check_value("pkt", 0, 32'(pkt));
            @(negedge clock);
        end
        random_tables();
        load_tables();
        run_packet(node_mem_pkg::hop_t'($urandom));
        report_test(1, "reset and first packet", err0);

        err0 = err_count;
        for (k = 0; k < 3; k++) begin
            random_tables();
            load_tables();
            run_packet(node_mem_pkg::hop_t'($urandom));
        end
        report_test(2, "random tables", err0);

        err0 = err_count;
        random_tables();
        for (k = 0; k < `NUM_NEIGHBORS; k++) begin
            qv_tab[k] = qv_tab[k] & 16'h7FFF;
        end
        qv_tab[5] = 16'hC000;
        qv_tab[2] = 16'hC000;  // lowest of the tied entries
        qv_tab[6] = 16'hC000;
        load_tables();
        run_packet(node_mem_pkg::hop_t'($urandom));
        report_test(3, "tied q-values", err0);

        err0 = err_count;
        prev = done_count;
        pulse_start();
        repeat (`NUM_NEIGHBORS + 12) @(negedge clock);
        check_value("done count", prev, done_count);
        report_test(4, "start with en low", err0);

        err0 = err_count;
        random_tables();
        load_tables();
        run_packet(node_mem_pkg::hop_t'($urandom));
        next_best = ref_best_hop() + 1'b1;
        random_tables();
        for (k = 0; k < `NUM_NEIGHBORS; k++) begin
            qv_tab[k] = qv_tab[k] & 16'h7FFF;
        end
        qv_tab[next_best] = 16'hFFFF;  // winner moves to a new index
        load_tables();
        run_packet(node_mem_pkg::hop_t'($urandom));
        report_test(5, "back-to-back packets", err0);

        $display("summary: %0d tests passed, %0d tests failed, %0d errors",
                 pass_count, fail_count, err_count);
        if (fail_count == 0 && err_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* sources.f */
+incdir+include
hdl/node_mem_pkg.sv
hdl/reward_pkg.sv
hdl/node_mem.sv
hdl/best_hop_finder.sv
hdl/reward_packet.sv
hdl/node_top.sv
tests/tb_node_top.sv

/* Makefile */
VERILATOR := verilator
TOP       := tb_node_top
FILELIST  := sources.f
FLAGS     := --binary --timing --assert --timescale 1ns/1ps
BUILD_DIR := obj_dir
SIM       := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
PASS_MSG  := STATUS: PASS

SOURCES := $(shell grep -v '^+' $(FILELIST)) include/node_defs.svh

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
